//--- compile.f
verilog/adapter_pkg.sv
verilog/axi_read_engine.sv
verilog/axi_write_engine.sv
verilog/req_dispatch.sv
verilog/axi_adapter_top.sv
sim/axi_mem_model.sv
sim/adapter_checker.sv
sim/tb_axi_adapter.sv

//--- Makefile
# Verilator build and regression run for the AXI adapter

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_axi_adapter -o tb_axi_adapter
	./obj_dir/tb_axi_adapter > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tb_axi_adapter.sv
// Testbench top for the cache-side AXI adapter.
// Builds a table of cache requests and applies it twice against the AXI
// memory model, which stalls every ready at random. The checker module
// compares all results; this module drives the table and ends the run.

`default_nettype none

module tb_axi_adapter;

  localparam int N_ENTRIES = 11;
  localparam int PASSES    = 2;

  logic                    clk;
  logic                    rst_n;
  logic                    req;
  adapter_pkg::cache_req_t req_data;
  logic                    gnt;
  adapter_pkg::cache_rsp_t rsp;
  logic                    busy;
  adapter_pkg::axi_req_t   axi_req;
  adapter_pkg::axi_rsp_t   axi_rsp;
  int                      tests;
  int                      errors;

  adapter_pkg::cache_req_t table_q[$];

  always #5 clk = ~clk;

  axi_adapter_top UUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .req_i      (req),
    .req_data_i (req_data),
    .gnt_o      (gnt),
    .rsp_o      (rsp),
    .busy_o     (busy),
    .axi_req_o  (axi_req),
    .axi_rsp_i  (axi_rsp)
  );

  axi_mem_model u_mem (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .axi_req_i (axi_req),
    .axi_rsp_o (axi_rsp)
  );

  adapter_checker u_check (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .req_data_i (req_data),
    .gnt_i      (gnt),
    .rsp_i      (rsp),
    .busy_i     (busy),
    .tests_o    (tests),
    .errors_o   (errors)
  );

  // line words are derived from the first word
  function automatic adapter_pkg::cache_req_t make_entry(
    logic we, adapter_pkg::req_type_e rt, logic [31:0] addr,
    logic [3:0] id, logic [63:0] w0, logic [7:0] be);
    adapter_pkg::cache_req_t e;
    e          = '0;
    e.req_type = rt;
    e.we       = we;
    e.addr     = addr;
    e.size     = 2'd3;
    e.id       = id;
    for (int i = 0; i < adapter_pkg::BEATS; i++) begin
      e.wdata[i] = w0 + 64'(i) * 64'h1111_1111_1111_1111;
      e.be[i]    = be;
    end
    return e;
  endfunction

  // hold the request until grant, then wait for its completion
  task automatic apply_entry(adapter_pkg::cache_req_t e);
    logic seen;
    @(posedge clk);
    req      <= 1'b1;
    req_data <= e;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = gnt;
    end
    @(posedge clk);
    req <= 1'b0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = rsp.valid;
    end
  endtask

  initial begin
    void'($urandom(23620));
    clk      = 1'b0;
    rst_n    = 1'b0;
    req      = 1'b0;
    req_data = '0;

    table_q.push_back(make_entry(1, adapter_pkg::SINGLE_REQ, 32'h100, 4'd1,
                                 64'h1122_3344_5566_7788, 8'hff));
    table_q.push_back(make_entry(1, adapter_pkg::SINGLE_REQ, 32'h100, 4'd2,
                                 64'haabb_ccdd_eeff_0011, 8'h0f));
    table_q.push_back(make_entry(0, adapter_pkg::SINGLE_REQ, 32'h100, 4'd3, '0, '0));
    table_q.push_back(make_entry(1, adapter_pkg::LINE_REQ, 32'h200, 4'd4,
                                 64'h0102_0304_0506_0708, 8'hff));
    table_q.push_back(make_entry(1, adapter_pkg::LINE_REQ, 32'h200, 4'd5,
                                 64'hf0e0_d0c0_b0a0_9080, 8'hf0));
    table_q.push_back(make_entry(0, adapter_pkg::LINE_REQ, 32'h218, 4'd6, '0, '0));
    table_q.push_back(make_entry(0, adapter_pkg::LINE_REQ, 32'h208, 4'd7, '0, '0));
    table_q.push_back(make_entry(0, adapter_pkg::SINGLE_REQ, 32'h210, 4'd8, '0, '0));
    table_q.push_back(make_entry(0, adapter_pkg::SINGLE_REQ, 32'h300, 4'd9, '0, '0));
    table_q.push_back(make_entry(1, adapter_pkg::SINGLE_REQ, 32'h308, 4'd10,
                                 64'h5a5a_5a5a_a5a5_a5a5, 8'h81));
    table_q.push_back(make_entry(0, adapter_pkg::LINE_REQ, 32'h300, 4'd11, '0, '0));

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // second pass repeats the table under new random stalls
    for (int p = 0; p < PASSES; p++) begin
      for (int i = 0; i < table_q.size(); i++) begin
        apply_entry(table_q[i]);
      end
    end
    repeat (5) @(posedge clk);

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0 && tests == N_ENTRIES * PASSES) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    repeat (N_ENTRIES * PASSES * 200 + 20) @(posedge clk);
    $display("timeout: the adapter stopped answering before all entries finished");
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/adapter_checker.sv
// Result checker for the adapter testbench.
// Watches grant, completion and busy, keeps a shadow memory updated on each
// write grant, and compares read lines, critical words and ids against it.
// Prints one line per finished request and hands the counts to the top.

`default_nettype none

module adapter_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  adapter_pkg::cache_req_t req_data_i,
  input  logic                    gnt_i,
  input  adapter_pkg::cache_rsp_t rsp_i,
  input  logic                    busy_i,
  output int                      tests_o,
  output int                      errors_o
);

  logic [63:0]             shadow [256];
  adapter_pkg::cache_req_t cur;
  logic                    pending;
  int                      gnt_cnt, crit_cnt, err_at_start;

  initial begin
    for (int i = 0; i < 256; i++) begin
      shadow[i] = '0;
    end
    pending  = 1'b0;
    tests_o  = 0;
    errors_o = 0;
  end

  task automatic report(string msg);
    $display("error at %0t: %s", $time, msg);
    errors_o++;
  endtask

  // word index touched by beat i of a request
  function automatic logic [7:0] word_of(adapter_pkg::cache_req_t r, int i);
    logic [7:0] w;
    w = r.addr[10:3];
    if (r.req_type == adapter_pkg::LINE_REQ) begin
      w = {r.addr[10:5], 2'b00} + 8'(i);
    end
    return w;
  endfunction

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (busy_i !== pending) begin
        report($sformatf("busy is %b, expected %b", busy_i, pending));
      end
      if (gnt_i) begin
        if (pending) begin
          gnt_cnt++;
        end else begin
          cur          = req_data_i;
          pending      = 1'b1;
          gnt_cnt      = 1;
          crit_cnt     = 0;
          err_at_start = errors_o;
          if (cur.we) begin
            for (int i = 0; i < (cur.req_type == adapter_pkg::LINE_REQ ? 4 : 1); i++) begin
              for (int b = 0; b < 8; b++) begin
                if (cur.be[i][b]) begin
                  shadow[word_of(cur, i)][8*b +: 8] = cur.wdata[i][8*b +: 8];
                end
              end
            end
          end
        end
      end
      if (rsp_i.critical_valid) begin
        crit_cnt++;
        if (rsp_i.critical_word !== shadow[cur.addr[10:3]]) begin
          report($sformatf("critical word %h, expected %h",
                           rsp_i.critical_word, shadow[cur.addr[10:3]]));
        end
      end
      if (rsp_i.valid) begin
        if (!pending) begin
          report("completion without a granted request");
        end
        if (rsp_i.id !== cur.id) begin
          report($sformatf("id %0d, expected %0d", rsp_i.id, cur.id));
        end
        if (!cur.we) begin
          for (int i = 0; i < (cur.req_type == adapter_pkg::LINE_REQ ? 4 : 1); i++) begin
            if (rsp_i.rdata[i] !== shadow[word_of(cur, i)]) begin
              report($sformatf("word %0d is %h, expected %h",
                               i, rsp_i.rdata[i], shadow[word_of(cur, i)]));
            end
          end
          if (crit_cnt != 1) begin
            report($sformatf("critical valid seen %0d times", crit_cnt));
          end
        end
        if (gnt_cnt != 1) begin
          report($sformatf("%0d grants for one request", gnt_cnt));
        end
        $display("test %0d: %s id %0d addr %h %s", tests_o,
                 cur.we ? "write" : "read", cur.id, cur.addr,
                 (errors_o == err_at_start) ? "ok" : "FAILED");
        tests_o++;
        pending = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/axi_mem_model.sv
// AXI memory slave for the adapter testbench.
// Starts all zero, serves one read burst and one write at a time and
// drops each ready at random. Only address bits 10 to 3 select a word.

`default_nettype none

module axi_mem_model (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  adapter_pkg::axi_req_t axi_req_i,
  output adapter_pkg::axi_rsp_t axi_rsp_o
);

  logic [63:0] mem [256];
  logic [63:0] wbuf [4];
  logic [7:0]  sbuf [4];

  logic       ar_rdy_q, aw_rdy_q, w_rdy_q;
  logic       rd_active, aw_got, w_done, b_valid;
  logic [7:0] rd_word, rd_beat, rd_len, aw_word, aw_len;
  logic [3:0] rd_id, aw_id;
  int         wcnt;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
  end

  always_comb begin
    axi_rsp_o          = '0;
    axi_rsp_o.ar_ready = ar_rdy_q && !rd_active;
    axi_rsp_o.aw_ready = aw_rdy_q && !aw_got;
    axi_rsp_o.w_ready  = w_rdy_q && !w_done;
    axi_rsp_o.r_valid  = rd_active;
    axi_rsp_o.r.data   = mem[rd_word + rd_beat];
    axi_rsp_o.r.id     = rd_id;
    axi_rsp_o.r.last   = (rd_beat == rd_len);
    axi_rsp_o.b_valid  = b_valid;
    axi_rsp_o.b.id     = aw_id;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {ar_rdy_q, aw_rdy_q, w_rdy_q} <= '0;
      {rd_active, aw_got, w_done, b_valid} <= '0;
      rd_beat <= '0;
      wcnt    <= 0;
    end else begin
      ar_rdy_q <= ($urandom % 4) != 0;
      aw_rdy_q <= ($urandom % 4) != 0;
      w_rdy_q  <= ($urandom % 4) != 0;
      if (axi_req_i.ar_valid && axi_rsp_o.ar_ready) begin
        rd_active <= 1'b1;
        rd_word   <= axi_req_i.ar.addr[10:3];
        rd_len    <= axi_req_i.ar.len;
        rd_id     <= axi_req_i.ar.id;
        rd_beat   <= '0;
      end else if (rd_active && axi_req_i.r_ready) begin
        if (rd_beat == rd_len) begin
          rd_active <= 1'b0;
        end else begin
          rd_beat <= rd_beat + 1'b1;
        end
      end
      if (axi_req_i.aw_valid && axi_rsp_o.aw_ready) begin
        aw_got  <= 1'b1;
        aw_word <= axi_req_i.aw.addr[10:3];
        aw_len  <= axi_req_i.aw.len;
        aw_id   <= axi_req_i.aw.id;
      end
      if (axi_req_i.w_valid && axi_rsp_o.w_ready) begin
        wbuf[wcnt] <= axi_req_i.w.data;
        sbuf[wcnt] <= axi_req_i.w.strb;
        wcnt       <= wcnt + 1;
        w_done     <= axi_req_i.w.last;
      end
      // commit once address and all data are in
      if (aw_got && w_done && !b_valid) begin
        for (int i = 0; i <= int'(aw_len); i++) begin
          for (int b = 0; b < 8; b++) begin
            if (sbuf[i][b]) begin
              mem[aw_word + 8'(i)][8*b +: 8] <= wbuf[i][8*b +: 8];
            end
          end
        end
        b_valid <= 1'b1;
      end
      if (b_valid && axi_req_i.b_ready) begin
        {b_valid, aw_got, w_done} <= '0;
        wcnt <= 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_adapter_top.sv
// Top level of the cache-side AXI adapter. Connects the request dispatcher
// to the read and write engines and gathers their bus fields into the
// single AXI request bundle.

`default_nettype none

module axi_adapter_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  adapter_pkg::cache_req_t req_data_i,
  output logic                    gnt_o,
  output adapter_pkg::cache_rsp_t rsp_o,
  output logic                    busy_o,
  output adapter_pkg::axi_req_t   axi_req_o,
  input  adapter_pkg::axi_rsp_t   axi_rsp_i
);

  logic                         rd_start;
  logic                         wr_start;
  logic                         rd_accept;
  logic                         wr_accept;
  logic                         rd_done;
  logic                         wr_done;
  adapter_pkg::cache_rsp_t      rd_rsp;
  logic [adapter_pkg::ID_W-1:0] wr_id;
  adapter_pkg::axi_ax_t         ar;
  adapter_pkg::axi_ax_t         aw;
  adapter_pkg::axi_w_t          w;
  logic                         ar_valid;
  logic                         aw_valid;
  logic                         w_valid;
  logic                         r_ready;
  logic                         b_ready;

  // read and write fields are disjoint
  assign axi_req_o = '{
    aw:       aw,
    aw_valid: aw_valid,
    w:        w,
    w_valid:  w_valid,
    b_ready:  b_ready,
    ar:       ar,
    ar_valid: ar_valid,
    r_ready:  r_ready
  };

  req_dispatch u_dispatch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .gnt_o       (gnt_o),
    .rsp_o       (rsp_o),
    .busy_o      (busy_o),
    .rd_start_o  (rd_start),
    .wr_start_o  (wr_start),
    .rd_accept_i (rd_accept),
    .wr_accept_i (wr_accept),
    .rd_done_i   (rd_done),
    .wr_done_i   (wr_done),
    .rd_rsp_i    (rd_rsp),
    .wr_id_i     (wr_id)
  );

  axi_read_engine u_read (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (rd_start),
    .req_data_i (req_data_i),
    .accept_o   (rd_accept),
    .done_o     (rd_done),
    .rsp_o      (rd_rsp),
    .ar_o       (ar),
    .ar_valid_o (ar_valid),
    .ar_ready_i (axi_rsp_i.ar_ready),
    .r_i        (axi_rsp_i.r),
    .r_valid_i  (axi_rsp_i.r_valid),
    .r_ready_o  (r_ready)
  );

  axi_write_engine u_write (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (wr_start),
    .req_data_i (req_data_i),
    .accept_o   (wr_accept),
    .done_o     (wr_done),
    .id_o       (wr_id),
    .aw_o       (aw),
    .aw_valid_o (aw_valid),
    .aw_ready_i (axi_rsp_i.aw_ready),
    .w_o        (w),
    .w_valid_o  (w_valid),
    .w_ready_i  (axi_rsp_i.w_ready),
    .b_i        (axi_rsp_i.b),
    .b_valid_i  (axi_rsp_i.b_valid),
    .b_ready_o  (b_ready)
  );

endmodule

`default_nettype wire

//--- verilog/req_dispatch.sv
// Front end toward the data cache. Hands each request to the read or the
// write engine, one transaction at a time, and turns the engines' accept
// and done pulses into the grant, the completion and the busy flag.

`default_nettype none

module req_dispatch (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  adapter_pkg::cache_req_t      req_data_i,
  output logic                         gnt_o,
  output adapter_pkg::cache_rsp_t      rsp_o,
  output logic                         busy_o,
  output logic                         rd_start_o,
  output logic                         wr_start_o,
  input  logic                         rd_accept_i,
  input  logic                         wr_accept_i,
  input  logic                         rd_done_i,
  input  logic                         wr_done_i,
  input  adapter_pkg::cache_rsp_t      rd_rsp_i,
  input  logic [adapter_pkg::ID_W-1:0] wr_id_i
);

  typedef enum logic [1:0] {
    IDLE,
    READING,
    WRITING
  } state_e;

  state_e state_q, state_d;

  logic                    granted_q;
  logic                    sel_wr;
  adapter_pkg::cache_rsp_t wr_rsp;

  // engines only start from idle, so one transaction is in flight
  assign rd_start_o = (state_q == IDLE) && req_i && !req_data_i.we;
  assign wr_start_o = (state_q == IDLE) && req_i && req_data_i.we;

  // engine that owns the request from its start cycle on
  assign sel_wr = (state_q == WRITING) || ((state_q == IDLE) && req_data_i.we);
  assign gnt_o  = sel_wr ? wr_accept_i : rd_accept_i;

  // a write completion carries only the id
  always_comb begin
    wr_rsp       = '0;
    wr_rsp.valid = wr_done_i;
    wr_rsp.id    = wr_id_i;
    rsp_o        = (state_q == WRITING) ? wr_rsp : rd_rsp_i;
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (rd_start_o) begin
          state_d = READING;
        end else if (wr_start_o) begin
          state_d = WRITING;
        end
      end
      READING: begin
        if (rd_done_i) begin
          state_d = IDLE;
        end
      end
      WRITING: begin
        if (wr_done_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      granted_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (rsp_o.valid) begin
        granted_q <= 1'b0;
      end else if (gnt_o) begin
        granted_q <= 1'b1;
      end
    end
  end

  // busy covers the span from the cycle after grant to the completion
  assign busy_o = granted_q && (state_q != IDLE);

  // a done pulse only comes from the engine that owns the transaction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rd_done_i && (state_q != READING)) && !(wr_done_i && (state_q != WRITING)))
    else $error("engine finished while another engine owned the transaction");

endmodule

`default_nettype wire

//--- verilog/axi_write_engine.sv
// Write side of the adapter. Drives AW and W for a single write or a line
// burst, with the two channels free to finish in either order, then waits
// for the B response. The accept pulse marks the end of the data phase and
// the done pulse carries the B id back to the dispatcher.

`default_nettype none

module axi_write_engine (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  adapter_pkg::cache_req_t      req_data_i,
  output logic                         accept_o,
  output logic                         done_o,
  output logic [adapter_pkg::ID_W-1:0] id_o,
  output adapter_pkg::axi_ax_t         aw_o,
  output logic                         aw_valid_o,
  input  logic                         aw_ready_i,
  output adapter_pkg::axi_w_t          w_o,
  output logic                         w_valid_o,
  input  logic                         w_ready_i,
  input  adapter_pkg::axi_b_t          b_i,
  input  logic                         b_valid_i,
  output logic                         b_ready_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_AW_W,
    WAIT_AW,
    WAIT_W,
    WAIT_B
  } state_e;

  state_e state_q, state_d;

  logic [adapter_pkg::BEAT_IDX_W-1:0] cnt_q;
  logic [adapter_pkg::BEAT_IDX_W-1:0] last_idx;
  logic [adapter_pkg::BEAT_IDX_W-1:0] beat_idx;
  logic                               is_line;
  logic                               starting;
  logic                               aw_pend;
  logic                               w_pend;
  logic                               aw_fire;
  logic                               w_fire;
  logic                               w_last_fire;
  logic                               aw_left;
  logic                               w_left;

  // the cache holds the request until accept, so it can be read directly
  assign is_line  = (req_data_i.req_type == adapter_pkg::LINE_REQ);
  assign last_idx = is_line ? adapter_pkg::BEAT_IDX_W'(adapter_pkg::BEATS - 1) : '0;
  assign beat_idx = is_line ? cnt_q : '0;
  assign starting = (state_q == IDLE) && start_i;

  // ----------------------------------------
  // channel bookkeeping
  // ----------------------------------------
  assign aw_pend = starting || (state_q == WAIT_AW_W) || (state_q == WAIT_AW);
  assign w_pend  = starting || (state_q == WAIT_AW_W) || (state_q == WAIT_W);

  assign aw_valid_o  = aw_pend;
  assign w_valid_o   = w_pend;
  assign aw_fire     = aw_valid_o && aw_ready_i;
  assign w_fire      = w_valid_o && w_ready_i;
  assign w_last_fire = w_fire && w_o.last;

  // what is still outstanding after this cycle
  assign aw_left = aw_pend && !aw_fire;
  assign w_left  = w_pend && !w_last_fire;

  assign accept_o = (aw_pend || w_pend) && !aw_left && !w_left;

  assign aw_o = adapter_pkg::make_ax(req_data_i);

  always_comb begin
    w_o.data = req_data_i.wdata[beat_idx];
    w_o.strb = req_data_i.be[beat_idx];
    w_o.last = (cnt_q == last_idx);
  end

  // response phase
  assign b_ready_o = (state_q == WAIT_B);
  assign done_o    = b_valid_i && b_ready_o;
  assign id_o      = b_i.id;

  always_comb begin
    state_d = state_q;
    if (aw_pend || w_pend) begin
      unique case ({aw_left, w_left})
        2'b11:   state_d = WAIT_AW_W;
        2'b10:   state_d = WAIT_AW;
        2'b01:   state_d = WAIT_W;
        default: state_d = WAIT_B;
      endcase
    end else if (done_o) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // counter is back at zero for the next request
      if (w_last_fire) begin
        cnt_q <= '0;
      end else if (w_fire) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // W is only raised while a beat of the held request is still to be sent
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o |-> (cnt_q <= last_idx))
    else $error("w_valid raised after all beats were sent");

endmodule

`default_nettype wire

//--- verilog/axi_read_engine.sv
// Read side of the adapter. Issues one AR per request, gathers the R beats
// into a line buffer and flags the beat that holds the requested word.
// The completion follows one cycle after the beat with last set.

`default_nettype none

module axi_read_engine (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  adapter_pkg::cache_req_t req_data_i,
  output logic                    accept_o,
  output logic                    done_o,
  output adapter_pkg::cache_rsp_t rsp_o,
  output adapter_pkg::axi_ax_t    ar_o,
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  input  adapter_pkg::axi_r_t     r_i,
  input  logic                    r_valid_i,
  output logic                    r_ready_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_AR,
    WAIT_R,
    COMPLETE
  } state_e;

  state_e state_q, state_d;

  logic [adapter_pkg::BEAT_IDX_W-1:0] cnt_q;
  logic [adapter_pkg::BEAT_IDX_W-1:0] crit_idx_q;
  logic [adapter_pkg::BEAT_IDX_W-1:0] last_idx;
  logic [adapter_pkg::BEAT_IDX_W-1:0] beat_idx;
  logic                               is_line_q;
  logic [adapter_pkg::ID_W-1:0]       id_q;
  logic [adapter_pkg::BEATS-1:0][adapter_pkg::DATA_W-1:0] line_q;
  logic                               r_fire;
  logic                               crit_hit;

  // ----------------------------------------
  // bus handshakes
  // ----------------------------------------
  // address phase comes straight from the held cache request
  assign ar_o       = adapter_pkg::make_ax(req_data_i);
  assign ar_valid_o = ((state_q == IDLE) && start_i) || (state_q == WAIT_AR);
  assign accept_o   = ar_valid_o && ar_ready_i;
  assign r_ready_o  = (state_q == WAIT_R);
  assign r_fire     = r_valid_i && r_ready_o;

  // single reads land in word 0
  assign last_idx = is_line_q ? adapter_pkg::BEAT_IDX_W'(adapter_pkg::BEATS - 1) : '0;
  assign beat_idx = is_line_q ? cnt_q : '0;
  assign crit_hit = !is_line_q || (cnt_q == crit_idx_q);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = ar_ready_i ? WAIT_R : WAIT_AR;
        end
      end
      WAIT_AR: begin
        if (ar_ready_i) begin
          state_d = WAIT_R;
        end
      end
      WAIT_R: begin
        if (r_fire && r_i.last) begin
          state_d = COMPLETE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      cnt_q      <= '0;
      is_line_q  <= 1'b0;
      crit_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept_o) begin
        cnt_q      <= '0;
        is_line_q  <= (req_data_i.req_type == adapter_pkg::LINE_REQ);
        crit_idx_q <= req_data_i.addr[adapter_pkg::LINE_OFFSET_W-1 -: adapter_pkg::BEAT_IDX_W];
      end else if (r_fire) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // line buffer and returned id
  always_ff @(posedge clk_i) begin
    if (r_fire) begin
      line_q[beat_idx] <= r_i.data;
      if (r_i.last) begin
        id_q <= r_i.id;
      end
    end
  end

  // ----------------------------------------
  // completion toward the cache
  // ----------------------------------------
  assign done_o = (state_q == COMPLETE);

  always_comb begin
    rsp_o.valid          = done_o;
    rsp_o.rdata          = line_q;
    rsp_o.id             = id_q;
    rsp_o.critical_word  = r_i.data;
    rsp_o.critical_valid = r_fire && crit_hit;
  end

  // AR must stay up with a fixed payload until the slave takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("ar_valid dropped or ar payload changed before ar_ready");

  // the slave must close the burst exactly at the requested length
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_fire |-> (r_i.last == (cnt_q == last_idx)))
    else $error("r last does not match the burst length");

endmodule

`default_nettype wire

//--- verilog/adapter_pkg.sv
// Shared widths, enums and packed structs for the cache-side AXI adapter.
// Covers the cache request/completion and the five AXI channels, plus the
// bundled request and response that travel between the adapter and the bus.
// Modules refer to everything here with adapter_pkg:: scoped names.

`default_nettype none

package adapter_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned ADDR_W        = 32;
  localparam int unsigned DATA_W        = 64;
  localparam int unsigned ID_W          = 4;
  localparam int unsigned LINE_W        = 256;
  localparam int unsigned STRB_W        = DATA_W / 8;
  localparam int unsigned BEATS         = LINE_W / DATA_W;
  localparam int unsigned BEAT_IDX_W    = $clog2(BEATS);
  localparam int unsigned LINE_OFFSET_W = $clog2(LINE_W / 8);
  // AXI size code for a full data-width beat
  localparam int unsigned FULL_SIZE     = $clog2(STRB_W);

  typedef enum logic {
    SINGLE_REQ = 1'b0,
    LINE_REQ   = 1'b1
  } req_type_e;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  // ----------------------------------------
  // cache side
  // ----------------------------------------
  typedef struct packed {
    req_type_e                            req_type;
    logic                                 we;
    logic [ADDR_W-1:0]                    addr;
    logic [BEATS-1:0][DATA_W-1:0]         wdata;
    logic [BEATS-1:0][STRB_W-1:0]         be;
    logic [1:0]                           size;
    logic [ID_W-1:0]                      id;
  } cache_req_t;

  typedef struct packed {
    logic                                 valid;
    logic [BEATS-1:0][DATA_W-1:0]         rdata;
    logic [ID_W-1:0]                      id;
    logic [DATA_W-1:0]                    critical_word;
    logic                                 critical_valid;
  } cache_rsp_t;

  // ----------------------------------------
  // AXI channels
  // ----------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    axi_burst_e        burst;
    logic [ID_W-1:0]   id;
  } axi_ax_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    logic [1:0]        resp;
    logic              last;
  } axi_r_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

  typedef struct packed {
    axi_ax_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ax_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   ar_ready;
    logic   w_ready;
    axi_r_t r;
    logic   r_valid;
    axi_b_t b;
    logic   b_valid;
  } axi_rsp_t;

  // address phase for AR and AW, line requests start at the line base
  function automatic axi_ax_t make_ax(cache_req_t req);
    axi_ax_t ax;
    ax.addr  = req.addr;
    ax.len   = 8'd0;
    ax.size  = {1'b0, req.size};
    ax.burst = INCR;
    ax.id    = req.id;
    if (req.req_type == LINE_REQ) begin
      ax.addr[LINE_OFFSET_W-1:0] = '0;
      ax.len  = 8'(BEATS - 1);
      ax.size = 3'(FULL_SIZE);
    end
    return ax;
  endfunction

endpackage

`default_nettype wire
